// File: logic/shift_pkg.sv
// Shift stage widths, register indices, shift-type codes and condition codes.

package shift_pkg;

        //////////////////////////////////////////////////
        // Datapath and register file.
        //////////////////////////////////////////////////

        // Width of every operand and result.
        localparam int data_w = 32;

        // Physical registers, including the banked copies.
        localparam int phy_regs = 46;

        // Index width needed to name any physical register.
        localparam int reg_idx_w = $clog2(phy_regs);

        // Issue source field, with the immediate flag on top.
        localparam int src_w = data_w + 1;

        // Flag value that marks the source field as an immediate.
        localparam logic immed_en = 1'b1;

        // Physical index that names the program counter.
        localparam int phy_pc = 15;

        //////////////////////////////////////////////////
        // Operation fields.
        //////////////////////////////////////////////////

        localparam int alu_op_w = 5;
        localparam int shift_op_w = 3;

        // Shift types.
        localparam logic [shift_op_w-1:0] sh_lsl = 3'd0;
        localparam logic [shift_op_w-1:0] sh_lsr = 3'd1;
        localparam logic [shift_op_w-1:0] sh_asr = 3'd2;
        localparam logic [shift_op_w-1:0] sh_ror = 3'd3;
        localparam logic [shift_op_w-1:0] sh_rrx = 3'd4;

        // Only the low byte of the length register counts.
        localparam int shamt_w = 8;

        //////////////////////////////////////////////////
        // Condition codes.
        //////////////////////////////////////////////////

        localparam int cc_w = 4;

        // Never executes; marks a bubble in the pipeline.
        localparam logic [cc_w-1:0] cc_nv = 4'd15;

endpackage

// File: logic/barrel_shifter.sv
// Barrel shifter for LSL, LSR, ASR, ROR and RRX with carry out.

`timescale 1ns/10ps

module barrel_shifter
(
        input  logic [shift_pkg::data_w-1:0]     i_source,
        input  logic [shift_pkg::shamt_w-1:0]    i_amount,
        input  logic [shift_pkg::shift_op_w-1:0] i_shift_type,
        input  logic                             i_carry,
        output logic [shift_pkg::data_w-1:0]     o_result,
        output logic                             o_carry
);

//////////////////////////////////////////////////

// Extended forms; the extra bit catches the last bit shifted out.
logic        [shift_pkg::data_w:0]       lsl_ext;
logic        [shift_pkg::data_w:0]       lsr_ext;
logic signed [shift_pkg::data_w:0]       asr_ext;
logic        [2*shift_pkg::data_w-1:0]   ror_ext;
logic                                    amount_zero;

//////////////////////////////////////////////////

always_comb
begin
        amount_zero = (i_amount == '0);

        // Carry lands in bit 32. Amounts past 32 shift everything out.
        lsl_ext = {1'b0, i_source} << i_amount;

        // Carry lands in bit 0, below the result.
        lsr_ext = {i_source, 1'b0} >> i_amount;

        // Sign fills from the top, so 32 and up give all sign bits.
        asr_ext = $signed({i_source, 1'b0}) >>> i_amount;

        // Rotate by amount mod 32 using a doubled copy.
        ror_ext = {i_source, i_source} >> i_amount[4:0];
end

//////////////////////////////////////////////////

always_comb
begin
        // Unknown codes and zero amounts pass straight through.
        o_result = i_source;
        o_carry  = i_carry;

        case (i_shift_type)
        shift_pkg::sh_lsl:
        begin
                if (!amount_zero)
                        {o_carry, o_result} = lsl_ext;
        end
        shift_pkg::sh_lsr:
        begin
                if (!amount_zero)
                        {o_result, o_carry} = lsr_ext;
        end
        shift_pkg::sh_asr:
        begin
                if (!amount_zero)
                        {o_result, o_carry} = asr_ext;
        end
        shift_pkg::sh_ror:
        begin
                // A multiple of 32 leaves the value and takes carry from bit 31.
                if (!amount_zero)
                begin
                        o_result = ror_ext[shift_pkg::data_w-1:0];
                        o_carry  = ror_ext[shift_pkg::data_w-1];
                end
        end
        shift_pkg::sh_rrx:
        begin
                // One bit right through the carry.
                o_result = {i_carry, i_source[shift_pkg::data_w-1:1]};
                o_carry  = i_source[0];
        end
        default:
        begin
                o_result = i_source;
                o_carry  = i_carry;
        end
        endcase
end

endmodule

// File: logic/operand_resolver.sv
// Operand forwarding from immediate, PC, ALU feedback or issue-read value.

`timescale 1ns/10ps

module operand_resolver
(
        // Index or immediate from issue, plus the value issue read.
        input  logic [shift_pkg::src_w-1:0]     i_index_from_issue,
        input  logic [shift_pkg::data_w-1:0]    i_value_from_issue,

        // Destination held in this stage's output register.
        input  logic [shift_pkg::reg_idx_w-1:0] i_index_this_stage,

        input  logic [shift_pkg::data_w-1:0]    i_pc_plus_8,

        // ALU result before it is registered.
        input  logic [shift_pkg::data_w-1:0]    i_alu_result,
        input  logic                            i_alu_result_valid,

        // Clear bits 1:0 of the result.
        input  logic                            i_align32,
        output logic [shift_pkg::data_w-1:0]    o_value
);

//////////////////////////////////////////////////

always_comb
begin
        // First match wins.
        if (i_index_from_issue[shift_pkg::src_w-1] == shift_pkg::immed_en)
        begin
                o_value = i_index_from_issue[shift_pkg::data_w-1:0];
        end
        else if (i_index_from_issue == shift_pkg::src_w'(shift_pkg::phy_pc))
        begin
                o_value = i_pc_plus_8;
        end
        else if (i_alu_result_valid &&
                 (i_index_from_issue[shift_pkg::reg_idx_w-1:0] == i_index_this_stage))
        begin
                // Instruction ahead writes this register; take it from the ALU.
                o_value = i_alu_result;
        end
        else
        begin
                o_value = i_value_from_issue;
        end

        if (i_align32)
                o_value[1:0] = 2'b00;
end

endmodule

// File: logic/shift_stage_pipe.sv
// Shifter or bypass select and the shift stage output register.

`timescale 1ns/10ps

module shift_stage_pipe
(
        input  logic                            i_clk,
        input  logic                            i_reset,

        // Stall and clear, highest priority first.
        input  logic                            i_clear_from_writeback,
        input  logic                            i_data_stall,
        input  logic                            i_clear_from_alu,

        // Result select.
        input  logic                            i_disable_shifter,
        input  logic                            i_cpsr_nxt_carry,
        input  logic [shift_pkg::data_w-1:0]    i_shift_result,
        input  logic                            i_shift_carry,

        // Resolved operands.
        input  logic [shift_pkg::data_w-1:0]    i_resolved_shift_source,
        input  logic [shift_pkg::data_w-1:0]    i_resolved_alu_source,
        input  logic [shift_pkg::data_w-1:0]    i_resolved_mem_srcdest,

        // Control fields from issue.
        input  logic [shift_pkg::cc_w-1:0]      i_condition_code,
        input  logic [shift_pkg::reg_idx_w-1:0] i_destination_index,
        input  logic [shift_pkg::alu_op_w-1:0]  i_alu_operation,
        input  logic                            i_flag_update,
        input  logic [shift_pkg::data_w-1:0]    i_pc_plus_8,

        output logic [shift_pkg::cc_w-1:0]      o_condition_code,
        output logic [shift_pkg::reg_idx_w-1:0] o_destination_index,
        output logic [shift_pkg::alu_op_w-1:0]  o_alu_operation,
        output logic                            o_flag_update,
        output logic [shift_pkg::data_w-1:0]    o_alu_source_value,
        output logic [shift_pkg::data_w-1:0]    o_shifted_source_value,
        output logic                            o_shift_carry,
        output logic [shift_pkg::data_w-1:0]    o_mem_srcdest_value,
        output logic [shift_pkg::data_w-1:0]    o_pc_plus_8
);

//////////////////////////////////////////////////

logic [shift_pkg::data_w-1:0] shifted_nxt;
logic                         carry_nxt;

//////////////////////////////////////////////////

always_comb
begin
        if (!i_disable_shifter)
        begin
                shifted_nxt = i_shift_result;
                carry_nxt   = i_shift_carry;
        end
        else
        begin
                // Bypass. Carry comes from next CPSR for back to back flag use.
                shifted_nxt = i_resolved_shift_source;
                carry_nxt   = i_cpsr_nxt_carry;
        end
end

//////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_condition_code       <= shift_pkg::cc_nv;
                o_destination_index    <= '0;
                o_alu_operation        <= '0;
                o_flag_update          <= 1'b0;
                o_alu_source_value     <= '0;
                o_shifted_source_value <= '0;
                o_shift_carry          <= 1'b0;
                o_mem_srcdest_value    <= '0;
                o_pc_plus_8            <= '0;
        end
        else if (i_clear_from_writeback)
        begin
                // Kill the instruction; the rest is don't-care.
                o_condition_code <= shift_pkg::cc_nv;
        end
        else if (i_data_stall)
        begin
                // Hold.
        end
        else if (i_clear_from_alu)
        begin
                o_condition_code <= shift_pkg::cc_nv;
        end
        else
        begin
                o_condition_code       <= i_condition_code;
                o_destination_index    <= i_destination_index;
                o_alu_operation        <= i_alu_operation;
                o_flag_update          <= i_flag_update;
                o_alu_source_value     <= i_resolved_alu_source;
                o_shifted_source_value <= shifted_nxt;
                o_shift_carry          <= carry_nxt;
                o_mem_srcdest_value    <= i_resolved_mem_srcdest;
                o_pc_plus_8            <= i_pc_plus_8;
        end
end

endmodule

// File: logic/shift_stage_top.sv
// Shift stage top level with three resolvers, the barrel shifter and the pipe.

`timescale 1ns/10ps

module shift_stage_top
(
        input  logic                              i_clk,
        input  logic                              i_reset,
        input  logic                              i_clear_from_writeback,
        input  logic                              i_data_stall,
        input  logic                              i_clear_from_alu,
        input  logic                              i_cpsr_nxt_carry,
        input  logic                              i_cpsr_ff_carry,
        input  logic [shift_pkg::cc_w-1:0]        i_condition_code,
        input  logic [shift_pkg::reg_idx_w-1:0]   i_destination_index,
        input  logic [shift_pkg::alu_op_w-1:0]    i_alu_operation,
        input  logic                              i_flag_update,
        input  logic [shift_pkg::shift_op_w-1:0]  i_shift_operation,
        input  logic                              i_disable_shifter,
        input  logic [shift_pkg::src_w-1:0]       i_alu_source,
        input  logic [shift_pkg::data_w-1:0]      i_alu_source_value,
        input  logic [shift_pkg::src_w-1:0]       i_shift_source,
        input  logic [shift_pkg::data_w-1:0]      i_shift_source_value,
        input  logic [shift_pkg::data_w-1:0]      i_shift_length_value,
        input  logic [shift_pkg::reg_idx_w-1:0]   i_mem_srcdest_index,
        input  logic [shift_pkg::data_w-1:0]      i_mem_srcdest_value,
        input  logic [shift_pkg::data_w-1:0]      i_pc_plus_8,
        input  logic                              i_force32align,
        input  logic [shift_pkg::data_w-1:0]      i_alu_value_nxt,
        input  logic                              i_alu_dav_nxt,
        output logic [shift_pkg::cc_w-1:0]        o_condition_code,
        output logic [shift_pkg::reg_idx_w-1:0]   o_destination_index,
        output logic [shift_pkg::alu_op_w-1:0]    o_alu_operation,
        output logic                              o_flag_update,
        output logic [shift_pkg::data_w-1:0]      o_alu_source_value,
        output logic [shift_pkg::data_w-1:0]      o_shifted_source_value,
        output logic                              o_shift_carry,
        output logic [shift_pkg::data_w-1:0]      o_mem_srcdest_value,
        output logic [shift_pkg::data_w-1:0]      o_pc_plus_8
);

//////////////////////////////////////////////////

logic [shift_pkg::data_w-1:0] alu_source_res;
logic [shift_pkg::data_w-1:0] shift_source_res;
logic [shift_pkg::data_w-1:0] mem_srcdest_res;
logic [shift_pkg::data_w-1:0] shift_result;
logic                         shift_carry;

//////////////////////////////////////////////////

// ALU source. Only this operand honours force32align.
operand_resolver u_alu_source_res
(
        .i_index_from_issue (i_alu_source),
        .i_value_from_issue (i_alu_source_value),
        .i_index_this_stage (o_destination_index),
        .i_pc_plus_8        (i_pc_plus_8),
        .i_alu_result       (i_alu_value_nxt),
        .i_alu_result_valid (i_alu_dav_nxt),
        .i_align32          (i_force32align),
        .o_value            (alu_source_res)
);

// Shift source, used on the bypass path.
operand_resolver u_shift_source_res
(
        .i_index_from_issue (i_shift_source),
        .i_value_from_issue (i_shift_source_value),
        .i_index_this_stage (o_destination_index),
        .i_pc_plus_8        (i_pc_plus_8),
        .i_alu_result       (i_alu_value_nxt),
        .i_alu_result_valid (i_alu_dav_nxt),
        .i_align32          (1'b0),
        .o_value            (shift_source_res)
);

// Store data. The index is never an immediate.
operand_resolver u_mem_srcdest_res
(
        .i_index_from_issue ({{(shift_pkg::src_w-shift_pkg::reg_idx_w){1'b0}},
                              i_mem_srcdest_index}),
        .i_value_from_issue (i_mem_srcdest_value),
        .i_index_this_stage (o_destination_index),
        .i_pc_plus_8        (i_pc_plus_8),
        .i_alu_result       (i_alu_value_nxt),
        .i_alu_result_valid (i_alu_dav_nxt),
        .i_align32          (1'b0),
        .o_value            (mem_srcdest_res)
);

//////////////////////////////////////////////////

// Shifter sees the issue value as read, unresolved.
barrel_shifter u_barrel_shifter
(
        .i_source     (i_shift_source_value),
        .i_amount     (i_shift_length_value[shift_pkg::shamt_w-1:0]),
        .i_shift_type (i_shift_operation),
        .i_carry      (i_cpsr_ff_carry),
        .o_result     (shift_result),
        .o_carry      (shift_carry)
);

//////////////////////////////////////////////////

shift_stage_pipe u_shift_stage_pipe
(
        .i_clk                   (i_clk),
        .i_reset                 (i_reset),
        .i_clear_from_writeback  (i_clear_from_writeback),
        .i_data_stall            (i_data_stall),
        .i_clear_from_alu        (i_clear_from_alu),
        .i_disable_shifter       (i_disable_shifter),
        .i_cpsr_nxt_carry        (i_cpsr_nxt_carry),
        .i_shift_result          (shift_result),
        .i_shift_carry           (shift_carry),
        .i_resolved_shift_source (shift_source_res),
        .i_resolved_alu_source   (alu_source_res),
        .i_resolved_mem_srcdest  (mem_srcdest_res),
        .i_condition_code        (i_condition_code),
        .i_destination_index     (i_destination_index),
        .i_alu_operation         (i_alu_operation),
        .i_flag_update           (i_flag_update),
        .i_pc_plus_8             (i_pc_plus_8),
        .o_condition_code        (o_condition_code),
        .o_destination_index     (o_destination_index),
        .o_alu_operation         (o_alu_operation),
        .o_flag_update           (o_flag_update),
        .o_alu_source_value      (o_alu_source_value),
        .o_shifted_source_value  (o_shifted_source_value),
        .o_shift_carry           (o_shift_carry),
        .o_mem_srcdest_value     (o_mem_srcdest_value),
        .o_pc_plus_8             (o_pc_plus_8)
);

endmodule

// File: tb/shift_stage_properties.sv
// Concurrent assertions on the shift stage output register, and their bind.

`timescale 1ns/10ps

module shift_stage_properties
(
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic                            i_clear_from_writeback,
        input  logic                            i_data_stall,
        input  logic                            i_clear_from_alu,
        input  logic                            i_disable_shifter,
        input  logic                            i_cpsr_nxt_carry,
        input  logic [shift_pkg::cc_w-1:0]      o_condition_code,
        input  logic [shift_pkg::reg_idx_w-1:0] o_destination_index,
        input  logic [shift_pkg::alu_op_w-1:0]  o_alu_operation,
        input  logic                            o_flag_update,
        input  logic [shift_pkg::data_w-1:0]    o_alu_source_value,
        input  logic [shift_pkg::data_w-1:0]    o_shifted_source_value,
        input  logic                            o_shift_carry,
        input  logic [shift_pkg::data_w-1:0]    o_mem_srcdest_value,
        input  logic [shift_pkg::data_w-1:0]    o_pc_plus_8
);

//////////////////////////////////////////////////

// High when the register takes a new instruction.
logic loading;

assign loading = !i_reset && !i_clear_from_writeback && !i_data_stall && !i_clear_from_alu;

//////////////////////////////////////////////////

// Reset leaves a bubble.
reset_gives_nv: assert property (@(posedge i_clk)
        i_reset |=> (o_condition_code == shift_pkg::cc_nv))
        else $error("condition code is not NV after reset");

// Stall holds everything unless reset or writeback clear wins.
stall_holds: assert property (@(posedge i_clk)
        (i_data_stall && !i_clear_from_writeback && !i_reset) |=>
                ($stable(o_condition_code) && $stable(o_destination_index) &&
                 $stable(o_alu_operation) && $stable(o_flag_update) &&
                 $stable(o_alu_source_value) && $stable(o_shifted_source_value) &&
                 $stable(o_shift_carry) && $stable(o_mem_srcdest_value) &&
                 $stable(o_pc_plus_8)))
        else $error("stage output changed during a data stall");

// Writeback clear kills the instruction, stall or not.
wb_clear_gives_nv: assert property (@(posedge i_clk)
        i_clear_from_writeback |=> (o_condition_code == shift_pkg::cc_nv))
        else $error("condition code is not NV after writeback clear");

// Bypass takes its carry from the next CPSR.
bypass_carry: assert property (@(posedge i_clk)
        (loading && i_disable_shifter) |=> (o_shift_carry == $past(i_cpsr_nxt_carry)))
        else $error("bypass carry does not follow the next CPSR carry");

endmodule

bind shift_stage_pipe shift_stage_properties props_i
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_disable_shifter      (i_disable_shifter),
        .i_cpsr_nxt_carry       (i_cpsr_nxt_carry),
        .o_condition_code       (o_condition_code),
        .o_destination_index    (o_destination_index),
        .o_alu_operation        (o_alu_operation),
        .o_flag_update          (o_flag_update),
        .o_alu_source_value     (o_alu_source_value),
        .o_shifted_source_value (o_shifted_source_value),
        .o_shift_carry          (o_shift_carry),
        .o_mem_srcdest_value    (o_mem_srcdest_value),
        .o_pc_plus_8            (o_pc_plus_8)
);

// File: tb/tb_shift_stage.sv
// Shift stage testbench with clock, reset, random stimulus, reference model and report.

`timescale 1ns/10ps

module tb_shift_stage;

localparam int reset_cycles  = 16;
localparam int shift_cycles  = 400;
localparam int bypass_cycles = 200;
localparam int fwd_cycles    = 300;
localparam int prio_cycles   = 400;

// Generous margin over the total test length.
localparam int cycle_limit = 4 * (reset_cycles + shift_cycles + bypass_cycles +
                                  fwd_cycles + prio_cycles);

logic        i_clk, i_reset;
logic        i_clear_from_writeback, i_data_stall, i_clear_from_alu;
logic        i_cpsr_nxt_carry, i_cpsr_ff_carry;
logic [3:0]  i_condition_code;
logic [5:0]  i_destination_index;
logic [4:0]  i_alu_operation;
logic        i_flag_update;
logic [2:0]  i_shift_operation;
logic        i_disable_shifter;
logic [32:0] i_alu_source, i_shift_source;
logic [31:0] i_alu_source_value, i_shift_source_value, i_shift_length_value;
logic [5:0]  i_mem_srcdest_index;
logic [31:0] i_mem_srcdest_value, i_pc_plus_8, i_alu_value_nxt;
logic        i_force32align, i_alu_dav_nxt;

logic [3:0]  o_condition_code;
logic [5:0]  o_destination_index;
logic [4:0]  o_alu_operation;
logic        o_flag_update, o_shift_carry;
logic [31:0] o_alu_source_value, o_shifted_source_value, o_mem_srcdest_value, o_pc_plus_8;

// Model of the stage register, one cycle ahead of the checks.
logic [3:0]  exp_cc;
logic [5:0]  exp_dest;
logic [4:0]  exp_aluop;
logic        exp_flag, exp_carry;
logic [31:0] exp_alu_src, exp_shifted, exp_mem, exp_pc8;
logic        model_live = 1'b0;

integer seed = 32'h844d9787;
int     errors = 0;
int     errors_before = 0;
int     tests_run = 0;
int     tests_failed = 0;
int     cycle_count = 0;

shift_stage_top dut_i (.*);

initial
begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
end

////////////////////////////////////////////////////

function automatic logic [31:0] draw_random;
        draw_random = $random(seed);
endfunction

// Shift rules written out case by case; returns carry above result.
function automatic logic [32:0] expect_shift(input logic [31:0] src, input logic [7:0] n,
                                             input logic [2:0] kind, input logic c);
        logic [31:0] r;
        logic        co;
        int          m;
        r  = src;
        co = c;
        m  = int'(n);
        case (kind)
        shift_pkg::sh_lsl:
        begin
                if (m >= 1 && m <= 31)
                begin
                        r  = src << n;
                        co = src[32-m];
                end
                else if (m >= 32)
                begin
                        r  = '0;
                        co = (m == 32) ? src[0] : 1'b0;
                end
        end
        shift_pkg::sh_lsr:
        begin
                if (m >= 1 && m <= 31)
                begin
                        r  = src >> n;
                        co = src[m-1];
                end
                else if (m >= 32)
                begin
                        r  = '0;
                        co = (m == 32) ? src[31] : 1'b0;
                end
        end
        shift_pkg::sh_asr:
        begin
                if (m >= 1 && m <= 31)
                begin
                        r  = $signed(src) >>> n;
                        co = src[m-1];
                end
                else if (m >= 32)
                begin
                        r  = {32{src[31]}};
                        co = src[31];
                end
        end
        shift_pkg::sh_ror:
        begin
                if (m != 0 && n[4:0] == 5'd0)
                        co = src[31];
                else if (m != 0)
                begin
                        r  = (src >> n[4:0]) | (src << (6'd32 - {1'b0, n[4:0]}));
                        co = r[31];
                end
        end
        shift_pkg::sh_rrx:
        begin
                r  = {c, src[31:1]};
                co = src[0];
        end
        default:
        begin
                r  = src;
                co = c;
        end
        endcase
        expect_shift = {co, r};
endfunction

// Forwarding order: immediate, PC, ALU result for this stage's destination, issue value.
function automatic logic [31:0] expect_operand(input logic [32:0] field,
                                               input logic [31:0] issue_value,
                                               input logic align);
        logic [31:0] v;
        if (field[32] == shift_pkg::immed_en)
                v = field[31:0];
        else if (field == 33'(shift_pkg::phy_pc))
                v = i_pc_plus_8;
        else if (i_alu_dav_nxt && field[5:0] == exp_dest)
                v = i_alu_value_nxt;
        else
                v = issue_value;
        if (align)
                v[1:0] = 2'b00;
        expect_operand = v;
endfunction

task automatic predict_next;
        logic [32:0] sh;
        logic [31:0] alu_res, shift_res, mem_res;
        sh        = expect_shift(i_shift_source_value, i_shift_length_value[7:0],
                                 i_shift_operation, i_cpsr_ff_carry);
        alu_res   = expect_operand(i_alu_source, i_alu_source_value, i_force32align);
        shift_res = expect_operand(i_shift_source, i_shift_source_value, 1'b0);
        mem_res   = expect_operand(33'(i_mem_srcdest_index), i_mem_srcdest_value, 1'b0);
        if (i_reset)
        begin
                exp_cc      = shift_pkg::cc_nv;
                exp_dest    = '0;
                exp_aluop   = '0;
                exp_flag    = 1'b0;
                exp_alu_src = '0;
                exp_shifted = '0;
                exp_carry   = 1'b0;
                exp_mem     = '0;
                exp_pc8     = '0;
        end
        else if (i_clear_from_writeback)
                exp_cc = shift_pkg::cc_nv;
        else if (!i_data_stall && i_clear_from_alu)
                exp_cc = shift_pkg::cc_nv;
        else if (!i_data_stall)
        begin
                exp_cc      = i_condition_code;
                exp_dest    = i_destination_index;
                exp_aluop   = i_alu_operation;
                exp_flag    = i_flag_update;
                exp_alu_src = alu_res;
                exp_shifted = i_disable_shifter ? shift_res : sh[31:0];
                exp_carry   = i_disable_shifter ? i_cpsr_nxt_carry : sh[32];
                exp_mem     = mem_res;
                exp_pc8     = i_pc_plus_8;
        end
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
                $display("CHECK FAILED at %0t: %s expected %h, got %h",
                         $time, name, expected, actual);
                errors++;
        end
endtask

////////////////////////////////////////////////////
// Checker: compare the last edge, then predict the next one.
////////////////////////////////////////////////////

always @(negedge i_clk)
begin
        if (model_live)
        begin
                check_value("o_condition_code", 32'(exp_cc), 32'(o_condition_code));
                check_value("o_destination_index", 32'(exp_dest), 32'(o_destination_index));
                check_value("o_alu_operation", 32'(exp_aluop), 32'(o_alu_operation));
                check_value("o_flag_update", 32'(exp_flag), 32'(o_flag_update));
                check_value("o_alu_source_value", exp_alu_src, o_alu_source_value);
                check_value("o_shifted_source_value", exp_shifted, o_shifted_source_value);
                check_value("o_shift_carry", 32'(exp_carry), 32'(o_shift_carry));
                check_value("o_mem_srcdest_value", exp_mem, o_mem_srcdest_value);
                check_value("o_pc_plus_8", exp_pc8, o_pc_plus_8);
        end
        predict_next();
        model_live = 1'b1;
end

always @(posedge i_clk)
begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
                $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
                $display("TB FAILED");
                $finish;
        end
end

////////////////////////////////////////////////////

// Amounts lean on the boundaries of the shift rules.
function automatic logic [7:0] pick_amount;
        logic [31:0] r;
        r = draw_random();
        case (r[3:1])
        3'd0:    pick_amount = 8'd0;
        3'd1:    pick_amount = 8'd31;
        3'd2:    pick_amount = 8'd32;
        3'd3:    pick_amount = 8'd33;
        3'd4:    pick_amount = 8'd255;
        default: pick_amount = r[15:8];
        endcase
endfunction

// Mode 0 immediate, 1 PC, 2 this stage's destination, 3 plain index.
function automatic logic [32:0] pick_field(input logic [1:0] mode);
        logic [31:0] r;
        r = draw_random();
        case (mode)
        2'd0:    pick_field = {shift_pkg::immed_en, r};
        2'd1:    pick_field = 33'(shift_pkg::phy_pc);
        2'd2:    pick_field = 33'(exp_dest);
        default: pick_field = {27'd0, r[5:0]};
        endcase
endfunction

// Called on a rising edge; everything except strobes and shifter enable.
task automatic drive_fields;
        logic [31:0] r;
        logic [31:0] len;
        logic [2:0]  op;
        r = draw_random();
        if (r[3:0] == 4'd0)
                op = r[6:4];
        else
                op = r[6:4] % 3'd5;
        len = draw_random();
        i_shift_operation    <= op;
        i_cpsr_nxt_carry     <= r[8];
        i_cpsr_ff_carry      <= r[9];
        i_flag_update        <= r[10];
        i_alu_dav_nxt        <= r[11];
        i_force32align       <= 1'b0;
        i_condition_code     <= r[15:12];
        i_destination_index  <= r[21:16];
        i_alu_operation      <= r[26:22];
        i_alu_source         <= pick_field(r[28:27]);
        i_shift_source       <= pick_field(r[30:29]);
        i_mem_srcdest_index  <= 6'(draw_random());
        i_alu_source_value   <= draw_random();
        i_shift_source_value <= draw_random();
        i_shift_length_value <= {len[31:8], pick_amount()};
        i_mem_srcdest_value  <= draw_random();
        i_pc_plus_8          <= draw_random();
        i_alu_value_nxt      <= draw_random();
endtask

task automatic end_test(input string name);
        repeat (2) @(posedge i_clk);
        tests_run++;
        if (errors == errors_before)
                $display("test %s: ok", name);
        else
        begin
                $display("test %s: %0d errors", name, errors - errors_before);
                tests_failed++;
        end
        errors_before = errors;
endtask

////////////////////////////////////////////////////

initial
begin
        logic [31:0] r;
        logic [32:0] f;
        i_reset = 1'b1;
        {i_clear_from_writeback, i_data_stall, i_clear_from_alu} = 3'b000;
        {i_cpsr_nxt_carry, i_cpsr_ff_carry, i_flag_update, i_disable_shifter} = 4'b0000;
        {i_force32align, i_alu_dav_nxt} = 2'b00;
        i_condition_code = '0;
        i_destination_index = '0;
        i_alu_operation = '0;
        i_shift_operation = '0;
        {i_alu_source, i_shift_source} = '0;
        {i_alu_source_value, i_shift_source_value, i_shift_length_value} = '0;
        i_mem_srcdest_index = '0;
        {i_mem_srcdest_value, i_pc_plus_8, i_alu_value_nxt} = '0;

        repeat (reset_cycles) @(posedge i_clk);
        i_reset <= 1'b0;
        end_test("reset state");

        repeat (shift_cycles)
        begin
                @(posedge i_clk);
                drive_fields();
                i_disable_shifter <= 1'b0;
        end
        end_test("barrel shifter");

        repeat (bypass_cycles)
        begin
                @(posedge i_clk);
                drive_fields();
                i_disable_shifter <= 1'b1;
        end
        end_test("bypass");

        // Store data has no immediate form, so its mode skips 0.
        repeat (fwd_cycles)
        begin
                @(posedge i_clk);
                drive_fields();
                r = draw_random();
                f = pick_field((r[1:0] == 2'd0) ? 2'd2 : r[1:0]);
                i_mem_srcdest_index <= f[5:0];
                i_disable_shifter   <= (r[4:3] != 2'b00);
                i_force32align      <= r[5];
        end
        end_test("forwarding");

        repeat (prio_cycles)
        begin
                @(posedge i_clk);
                drive_fields();
                r = draw_random();
                i_data_stall           <= (r[1:0] == 2'd0);
                i_clear_from_writeback <= (r[3:2] == 2'd0);
                i_clear_from_alu       <= (r[5:4] == 2'd0);
                i_disable_shifter      <= r[6];
        end
        @(posedge i_clk);
        {i_clear_from_writeback, i_data_stall, i_clear_from_alu} <= 3'b000;
        end_test("stall and clear priority");

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
                $display("TB PASSED");
        else
                $display("TB FAILED");
        $finish;
end

endmodule

// File: build.f
logic/shift_pkg.sv
logic/barrel_shifter.sv
logic/operand_resolver.sv
logic/shift_stage_pipe.sv
logic/shift_stage_top.sv
tb/shift_stage_properties.sv
tb/tb_shift_stage.sv

// File: run.sh
#!/usr/bin/env bash
# Build the shift stage testbench with Verilator, run it and look for the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
        -f build.f --top-module tb_shift_stage -Mdir obj_dir -o sim_shift_stage

output=$(./obj_dir/sim_shift_stage)
echo "$output"

if grep -q "^TB PASSED$" <<< "$output"
then
        exit 0
else
        exit 1
fi
